/* common/core_pkg.sv */
package core_pkg;

  // datapath widths
  localparam int ADDR_W     = 16;  // word addresses
  localparam int DATA_W     = 32;
  localparam int REG_IDX_W  = 5;

  localparam int NUM_REGS   = 32;
  localparam int DMEM_DEPTH = 256;  // words
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam addr_t RESET_PC = '0;

endpackage : core_pkg

/* common/isa_pkg.sv */
package isa_pkg;

  localparam int OPCODE_W = 4;
  localparam int IMM_W    = 13;

  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_ADDI  = 4'd5,
    OP_LOAD  = 4'd6,
    OP_STORE = 4'd7,
    OP_BEQ   = 4'd8,
    OP_JUMP  = 4'd9
  } opcode_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word
  //   [31:28] opcode
  //   [27:23] rd
  //   [22:18] ra
  //   [17:13] rb
  //   [12:0]  imm, two's complement
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    opcode_e                 opcode;
    core_pkg::reg_idx_t      rd;
    core_pkg::reg_idx_t      ra;
    core_pkg::reg_idx_t      rb;
    logic signed [IMM_W-1:0] imm;
  } instruction_t;

  function automatic core_pkg::data_t sext_imm(input logic signed [IMM_W-1:0] imm);
    return {{(core_pkg::DATA_W - IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

endpackage : isa_pkg

/* common/dec_exe_if.sv */
`timescale 1ns/1ps

interface dec_exe_if;
  import core_pkg::*;
  import isa_pkg::*;

  logic     valid;
  addr_t    pc;
  opcode_e  opcode;
  reg_idx_t rd;
  logic     wr_en;
  data_t    a_data;
  data_t    b_data;
  data_t    imm;  // sign extended in decode

  modport producer (output valid, pc, opcode, rd, wr_en, a_data, b_data, imm);
  modport consumer (input  valid, pc, opcode, rd, wr_en, a_data, b_data, imm);

endinterface : dec_exe_if

/* common/exe_mem_if.sv */
`timescale 1ns/1ps

interface exe_mem_if;
  import core_pkg::*;

  logic     valid;
  addr_t    pc;
  data_t    result;  // alu result or data memory address
  data_t    store_data;
  reg_idx_t rd;
  logic     wr_en;
  logic     is_load;
  logic     is_store;

  modport producer (output valid, pc, result, store_data, rd, wr_en, is_load, is_store);
  modport consumer (input  valid, pc, result, store_data, rd, wr_en, is_load, is_store);

endinterface : exe_mem_if

/* fetch/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  redirect_i,
  input  core_pkg::addr_t       redirect_pc_i,
  input  logic                  instr_valid_i,
  input  isa_pkg::instruction_t instr_i,
  output logic                  imem_req_valid_o,
  output core_pkg::addr_t       imem_req_pc_o,
  output logic                  dec_valid_o,
  output core_pkg::addr_t       dec_pc_o,
  output isa_pkg::instruction_t instruction_o
);
  import core_pkg::*;

  logic  req_valid_q;
  logic  drop_q;   // answer in this cycle belongs to the old path
  addr_t pc_q;     // address whose answer arrives this cycle
  logic  accept;

  assign accept = req_valid_q && instr_valid_i && !drop_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign imem_req_valid_o = req_valid_q;
  assign imem_req_pc_o    = accept ? pc_q + addr_t'(1) : pc_q;  // a missed answer is asked again

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      req_valid_q <= 1'b0;
      drop_q      <= 1'b0;
      pc_q        <= RESET_PC;
    end else begin
      req_valid_q <= 1'b1;
      drop_q      <= redirect_i;  // one shot
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else begin
        pc_q <= imem_req_pc_o;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch to decode register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= accept && !redirect_i;  // word arriving with a redirect is wrong path
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_pc_o      <= pc_q;
      instruction_o <= instr_i;
    end
  end

  // a stalled memory must be asked for the same address again
  pc_hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    (req_valid_q && !instr_valid_i && !drop_q) |-> (imem_req_pc_o == $past(imem_req_pc_o))
  ) else $error("fetch pc advanced without a valid instruction");

endmodule : fetch_stage

/* decode/rbank.sv */
`timescale 1ns/1ps

module rbank (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               wr_en_i,
  input  core_pkg::reg_idx_t wr_reg_i,
  input  core_pkg::data_t    wr_data_i,
  input  core_pkg::reg_idx_t rd_reg_a_i,
  input  core_pkg::reg_idx_t rd_reg_b_i,
  output core_pkg::data_t    reg_a_data_o,
  output core_pkg::data_t    reg_b_data_o
);
  import core_pkg::*;

  data_t regs [NUM_REGS];

  // write-through so a read in the write cycle sees the new value
  function automatic data_t read_port(input reg_idx_t idx);
    if (wr_en_i && (wr_reg_i == idx) && (idx != '0)) begin
      return wr_data_i;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_reg_i != '0)) begin  // r0 stays zero
      regs[wr_reg_i] <= wr_data_i;
    end
  end

  assign reg_a_data_o = read_port(rd_reg_a_i);
  assign reg_b_data_o = read_port(rd_reg_b_i);

  // decode never enables a write to r0
  no_r0_write: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    wr_en_i |-> (wr_reg_i != '0)
  ) else $error("write to r0 reached the register bank");

endmodule : rbank

/* decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  core_pkg::addr_t       pc_i,
  input  isa_pkg::instruction_t instruction_i,
  input  logic                  redirect_i,
  output core_pkg::reg_idx_t    rd_reg_a_o,
  output core_pkg::reg_idx_t    rd_reg_b_o,
  input  core_pkg::data_t       reg_a_data_i,
  input  core_pkg::data_t       reg_b_data_i,
  dec_exe_if.producer           exe
);
  import isa_pkg::*;

  opcode_e opcode;
  logic    writes_rd;
  logic    wr_en;

  assign opcode     = instruction_i.opcode;
  assign rd_reg_a_o = instruction_i.ra;  // rbank read, answer comes back this cycle
  assign rd_reg_b_o = instruction_i.rb;

  always_comb begin
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LOAD: begin
        writes_rd = 1'b1;
      end
      default: begin
        writes_rd = 1'b0;  // nop, store, beq, jump and unknown codes
      end
    endcase
  end

  // r0 writes are dropped here
  assign wr_en = writes_rd && (instruction_i.rd != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode to execute register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= valid_i && !redirect_i;
    end
  end

  always_ff @(posedge clk_i) begin
    exe.pc     <= pc_i;
    exe.opcode <= opcode;
    exe.rd     <= instruction_i.rd;
    exe.wr_en  <= wr_en;
    exe.a_data <= reg_a_data_i;
    exe.b_data <= reg_b_data_i;
    exe.imm    <= sext_imm(instruction_i.imm);
  end

  // both squashed slots must reach the alu as bubbles
  squash_on_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    ($past(redirect_i) || $past(redirect_i, 2)) |-> !exe.valid
  ) else $error("decode passed an instruction behind a taken branch");

endmodule : decode_stage

/* execute/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
  input  logic          clk_i,
  input  logic          rst_i,
  dec_exe_if.consumer   exe,
  exe_mem_if.producer   mem,
  output logic          redirect_o,
  output core_pkg::addr_t redirect_pc_o
);
  import core_pkg::*;
  import isa_pkg::*;

  data_t result;
  data_t sum_imm;
  logic  is_beq;
  logic  is_jump;
  logic  operands_eq;
  addr_t branch_target;

  assign sum_imm = exe.a_data + exe.imm;  // addi, load and store address

  always_comb begin
    case (exe.opcode)
      OP_ADD: begin
        result = exe.a_data + exe.b_data;
      end
      OP_SUB: begin
        result = exe.a_data - exe.b_data;
      end
      OP_AND: begin
        result = exe.a_data & exe.b_data;
      end
      OP_OR: begin
        result = exe.a_data | exe.b_data;
      end
      default: begin
        result = sum_imm;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch resolution
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign is_beq        = (exe.opcode == OP_BEQ);
  assign is_jump       = (exe.opcode == OP_JUMP);
  assign operands_eq   = (exe.a_data == exe.b_data);
  assign branch_target = exe.pc + addr_t'(exe.imm);  // pc relative

  assign redirect_o    = exe.valid && ((is_beq && operands_eq) || is_jump);
  assign redirect_pc_o = is_jump ? addr_t'(exe.imm) : branch_target;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute to memory register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem.valid <= 1'b0;
    end else begin
      mem.valid <= exe.valid;  // branch itself keeps going and retires
    end
  end

  always_ff @(posedge clk_i) begin
    mem.pc         <= exe.pc;
    mem.result     <= result;
    mem.store_data <= exe.b_data;
    mem.rd         <= exe.rd;
    mem.wr_en      <= exe.wr_en;
    mem.is_load    <= (exe.opcode == OP_LOAD);
    mem.is_store   <= (exe.opcode == OP_STORE);
  end

endmodule : alu_stage

/* memory/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  exe_mem_if.consumer        mem,
  output logic               wr_en_o,
  output core_pkg::reg_idx_t wr_reg_o,
  output core_pkg::data_t    wr_data_o,
  output logic               retire_valid_o,
  output core_pkg::addr_t    retire_pc_o
);
  import core_pkg::*;

  data_t              dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] dmem_idx;
  data_t              load_data_q;

  logic     wb_valid_q;
  logic     wb_wr_en_q;
  logic     wb_is_load_q;
  reg_idx_t wb_rd_q;
  data_t    wb_result_q;
  addr_t    wb_pc_q;

  assign dmem_idx = mem.result[DMEM_AW-1:0];  // upper address bits ignored

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data memory, synchronous read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (mem.valid && mem.is_store) begin
      dmem[dmem_idx] <= mem.store_data;
    end
    load_data_q <= dmem[dmem_idx];
  end

  // write-back register
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_q <= 1'b0;
      wb_wr_en_q <= 1'b0;
    end else begin
      wb_valid_q <= mem.valid;
      wb_wr_en_q <= mem.valid && mem.wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_is_load_q <= mem.is_load;
    wb_rd_q      <= mem.rd;
    wb_result_q  <= mem.result;
    wb_pc_q      <= mem.pc;
  end

  assign wr_en_o   = wb_wr_en_q;
  assign wr_reg_o  = wb_rd_q;
  assign wr_data_o = wb_is_load_q ? load_data_q : wb_result_q;

  assign retire_valid_o = wb_valid_q;
  assign retire_pc_o    = wb_pc_q;

endmodule : mem_stage

/* source/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  imem_instr_valid_i,
  input  isa_pkg::instruction_t imem_instr_i,
  output logic                  imem_req_valid_o,
  output core_pkg::addr_t       pc_o,
  output logic                  retire_valid_o,
  output core_pkg::addr_t       retire_pc_o,
  output logic                  retire_wr_en_o,
  output core_pkg::reg_idx_t    retire_wr_reg_o,
  output core_pkg::data_t       retire_wr_data_o
);
  import core_pkg::*;
  import isa_pkg::*;

  logic         redirect;
  addr_t        redirect_pc;

  logic         dec_valid;
  addr_t        dec_pc;
  instruction_t dec_instr;

  reg_idx_t     rd_reg_a;
  reg_idx_t     rd_reg_b;
  data_t        reg_a_data;
  data_t        reg_b_data;

  dec_exe_if dec_exe ();
  exe_mem_if exe_mem ();

  fetch_stage u_fetch (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .instr_valid_i    (imem_instr_valid_i),
    .instr_i          (imem_instr_i),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_pc_o    (pc_o),
    .dec_valid_o      (dec_valid),
    .dec_pc_o         (dec_pc),
    .instruction_o    (dec_instr)
  );

  decode_stage u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (dec_valid),
    .pc_i          (dec_pc),
    .instruction_i (dec_instr),
    .redirect_i    (redirect),
    .rd_reg_a_o    (rd_reg_a),
    .rd_reg_b_o    (rd_reg_b),
    .reg_a_data_i  (reg_a_data),
    .reg_b_data_i  (reg_b_data),
    .exe           (dec_exe)
  );

  // write port is shared with the retire outputs
  rbank u_rbank (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (retire_wr_en_o),
    .wr_reg_i     (retire_wr_reg_o),
    .wr_data_i    (retire_wr_data_o),
    .rd_reg_a_i   (rd_reg_a),
    .rd_reg_b_i   (rd_reg_b),
    .reg_a_data_o (reg_a_data),
    .reg_b_data_o (reg_b_data)
  );

  alu_stage u_alu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .exe           (dec_exe),
    .mem           (exe_mem),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  mem_stage u_mem (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mem            (exe_mem),
    .wr_en_o        (retire_wr_en_o),
    .wr_reg_o       (retire_wr_reg_o),
    .wr_data_o      (retire_wr_data_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o)
  );

endmodule : cpu

/* verification/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int RESET_CYCLES     = 16;
  localparam int IMEM_DEPTH       = 1024;
  localparam int IMEM_AW          = $clog2(IMEM_DEPTH);
  localparam int CYCLES_PER_INSTR = 8;

  typedef struct packed {
    addr_t    pc;
    logic     wr_en;
    reg_idx_t rd;
    data_t    data;
  } retire_t;

  logic         clk              = 1'b0;
  logic         rst              = 1'b0;
  logic         imem_instr_valid = 1'b0;
  instruction_t imem_instr       = '0;
  logic         imem_req_valid;
  addr_t        pc_o;
  logic         retire_valid;
  addr_t        retire_pc;
  logic         retire_wr_en;
  reg_idx_t     retire_wr_reg;
  data_t        retire_wr_data;

  instruction_t imem [IMEM_DEPTH];
  instruction_t prog [$];
  instruction_t alu_prog [$];  // kept for the stall rerun
  retire_t      expected [$];
  data_t        lcg_state   = 32'd59;
  logic         stall_en    = 1'b0;
  data_t        stall_rnd;
  int           cycle_count = 0;
  int           deadline    = 2 * RESET_CYCLES;

  always #10 clk = ~clk;

  cpu dut_i (
    .clk_i              (clk),
    .rst_i              (rst),
    .imem_instr_valid_i (imem_instr_valid),
    .imem_instr_i       (imem_instr),
    .imem_req_valid_o   (imem_req_valid),
    .pc_o               (pc_o),
    .retire_valid_o     (retire_valid),
    .retire_pc_o        (retire_pc),
    .retire_wr_en_o     (retire_wr_en),
    .retire_wr_reg_o    (retire_wr_reg),
    .retire_wr_data_o   (retire_wr_data)
  );

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic signed [IMM_W-1:0] rand_imm();
    data_t r;
    r = lcg_next();
    return r[28:16];  // upper bits of the lcg are the better ones
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction memory, answers one cycle later
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (stall_en) begin
      stall_rnd = lcg_next();
    end else begin
      stall_rnd = '1;
    end
    imem_instr_valid <= imem_req_valid && (stall_rnd[31:30] != 2'b00);
    imem_instr       <= imem[pc_o[IMEM_AW-1:0]];
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > deadline) begin
      $display("Watchdog expired after %0d cycles before all tests finished", cycle_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_equal(input string name, input data_t got, input data_t want);
    assert (got === want) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic emit(input opcode_e op, input reg_idx_t rd, input reg_idx_t ra,
                      input reg_idx_t rb, input logic signed [IMM_W-1:0] imm);
    instruction_t w;
    w.opcode = op;
    w.rd     = rd;
    w.ra     = ra;
    w.rb     = rb;
    w.imm    = imm;
    prog.push_back(w);
  endtask

  task automatic emit_nops(input int n);
    repeat (n) emit(OP_NOP, 5'd0, 5'd0, 5'd0, 13'd0);
  endtask

  task automatic load_imem();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      if (i < prog.size()) begin
        imem[i] = prog[i];
      end else begin
        imem[i] = instruction_t'({OP_NOP, 18'd0, i[IMEM_AW-1:0]});  // nop tagged with its address
      end
    end
  endtask

  // architectural model of the program, one retire event per executed word
  task automatic predict_retires();
    data_t        regs [NUM_REGS];
    data_t        dmem [DMEM_DEPTH];
    instruction_t w;
    retire_t      ev;
    data_t        a;
    data_t        b;
    data_t        imm;
    data_t        addr;
    logic         writes;
    int           pc;
    int           next_pc;
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    expected.delete();
    pc = 0;
    while ((pc < prog.size()) && (expected.size() < IMEM_DEPTH)) begin
      w       = prog[pc];
      a       = regs[w.ra];
      b       = regs[w.rb];
      imm     = data_t'(int'(w.imm));
      addr    = a + imm;
      writes  = 1'b1;
      next_pc = pc + 1;
      ev.data = '0;
      case (w.opcode)
        OP_ADD:  ev.data = a + b;
        OP_SUB:  ev.data = a - b;
        OP_AND:  ev.data = a & b;
        OP_OR:   ev.data = a | b;
        OP_ADDI: ev.data = addr;
        OP_LOAD: ev.data = dmem[addr[DMEM_AW-1:0]];
        default: writes  = 1'b0;
      endcase
      if (w.opcode == OP_STORE) begin
        dmem[addr[DMEM_AW-1:0]] = b;
      end
      if ((w.opcode == OP_BEQ) && (a == b)) begin
        next_pc = pc + int'(w.imm);
      end
      if (w.opcode == OP_JUMP) begin
        next_pc = int'(addr_t'(imm));  // absolute target
      end
      ev.pc    = addr_t'(pc);
      ev.rd    = w.rd;
      ev.wr_en = writes && (w.rd != 5'd0);
      if (ev.wr_en) begin
        regs[w.rd] = ev.data;
      end
      expected.push_back(ev);
      pc = next_pc;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;
  endtask

  task automatic check_retire(input int idx);
    retire_t e;
    e = expected[idx];
    check_equal("retire_pc_o", data_t'(retire_pc), data_t'(e.pc));
    check_equal("retire_wr_en_o", data_t'(retire_wr_en), data_t'(e.wr_en));
    if (e.wr_en) begin
      check_equal("retire_wr_reg_o", data_t'(retire_wr_reg), data_t'(e.rd));
      check_equal("retire_wr_data_o", retire_wr_data, e.data);
    end
  endtask

  task automatic run_program(input logic with_stalls);
    int seen;
    load_imem();
    predict_retires();
    stall_en = with_stalls;
    deadline += prog.size() * CYCLES_PER_INSTR + RESET_CYCLES + 2;
    apply_reset();
    seen = 0;
    while (seen < expected.size()) begin
      @(posedge clk);
      if (retire_valid) begin
        check_retire(seen);
        seen++;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_reset_state();
    deadline += 2 * RESET_CYCLES;
    @(posedge clk);
    rst <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      check_equal("imem_req_valid_o", data_t'(imem_req_valid), 32'd0);
      check_equal("retire_valid_o", data_t'(retire_valid), 32'd0);
    end
    rst <= 1'b1;
    do begin
      @(posedge clk);
      check_equal("retire_valid_o", data_t'(retire_valid), 32'd0);
    end while (!imem_req_valid);
    check_equal("pc_o", data_t'(pc_o), 32'd0);  // first request
  endtask

  task automatic test_alu_ops();
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
      emit(OP_ADDI, reg_idx_t'(r), 5'd0, 5'd0, rand_imm());
    end
    emit_nops(3);
    emit(OP_ADD, 5'd5, 5'd1, 5'd2, 13'd0);
    emit(OP_SUB, 5'd6, 5'd3, 5'd4, 13'd0);
    emit(OP_AND, 5'd7, 5'd1, 5'd3, 13'd0);
    emit(OP_OR, 5'd8, 5'd2, 5'd4, 13'd0);
    emit(OP_ADDI, 5'd0, 5'd1, 5'd0, 13'd5);  // r0 destination
    emit(OP_ADD, 5'd0, 5'd3, 5'd4, 13'd0);
    emit(OP_SUB, 5'd9, 5'd5, 5'd6, 13'd0);
    emit(OP_OR, 5'd10, 5'd7, 5'd8, 13'd0);
    emit_nops(3);
    emit(OP_AND, 5'd11, 5'd9, 5'd10, 13'd0);
    emit_nops(2);
    alu_prog = prog;
    run_program(1'b0);
  endtask

  task automatic test_memory();
    logic signed [IMM_W-1:0] base;
    prog.delete();
    base = rand_imm();
    emit(OP_ADDI, 5'd1, 5'd0, 5'd0, rand_imm());
    emit(OP_ADDI, 5'd2, 5'd0, 5'd0, rand_imm());
    emit(OP_ADDI, 5'd3, 5'd0, 5'd0, {6'd0, base[6:0]});
    emit_nops(3);
    emit(OP_STORE, 5'd0, 5'd3, 5'd1, 13'd0);
    emit(OP_STORE, 5'd0, 5'd3, 5'd2, 13'd1);
    emit(OP_LOAD, 5'd4, 5'd3, 5'd0, 13'd0);
    emit(OP_LOAD, 5'd5, 5'd3, 5'd0, 13'd1);
    emit(OP_STORE, 5'd0, 5'd3, 5'd1, 13'h1fff);  // negative offset
    emit(OP_LOAD, 5'd6, 5'd3, 5'd0, 13'h1fff);
    emit_nops(3);
    emit(OP_ADD, 5'd7, 5'd4, 5'd5, 13'd0);
    emit_nops(1);
    run_program(1'b0);
  endtask

  task automatic test_branches();
    logic signed [IMM_W-1:0] v;
    prog.delete();
    v = rand_imm();
    emit(OP_ADDI, 5'd1, 5'd0, 5'd0, v);
    emit(OP_ADDI, 5'd2, 5'd0, 5'd0, v);
    emit(OP_ADDI, 5'd3, 5'd0, 5'd0, {v[IMM_W-1:1], ~v[0]});
    emit_nops(3);
    emit(OP_BEQ, 5'd0, 5'd1, 5'd2, 13'd4);  // taken, lands on 10
    emit(OP_ADDI, 5'd4, 5'd0, 5'd0, 13'd1);
    emit(OP_ADDI, 5'd4, 5'd0, 5'd0, 13'd2);
    emit(OP_ADDI, 5'd4, 5'd0, 5'd0, 13'd3);
    emit(OP_BEQ, 5'd0, 5'd1, 5'd3, 13'd5);  // not taken
    emit(OP_ADDI, 5'd5, 5'd0, 5'd0, 13'd11);
    emit(OP_JUMP, 5'd0, 5'd0, 5'd0, 13'd16);
    emit(OP_ADDI, 5'd6, 5'd0, 5'd0, 13'd1);
    emit(OP_ADDI, 5'd6, 5'd0, 5'd0, 13'd2);
    emit(OP_ADDI, 5'd6, 5'd0, 5'd0, 13'd3);
    emit(OP_ADDI, 5'd7, 5'd1, 5'd0, 13'd1);
    emit(OP_BEQ, 5'd0, 5'd0, 5'd0, 13'd3);
    emit(OP_ADDI, 5'd8, 5'd0, 5'd0, 13'd1);
    emit(OP_ADDI, 5'd8, 5'd0, 5'd0, 13'd2);
    emit(OP_ADDI, 5'd9, 5'd0, 5'd0, 13'd9);
    emit_nops(2);
    run_program(1'b0);
  endtask

  task automatic test_stalls();
    prog = alu_prog;
    run_program(1'b1);
  endtask

  initial begin
    check_reset_state();
    $display("reset checks done");
    test_alu_ops();
    test_memory();
    test_branches();
    test_stalls();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : cpu_tb

/* compile.f */
common/core_pkg.sv
common/isa_pkg.sv
common/dec_exe_if.sv
common/exe_mem_if.sv
fetch/fetch_stage.sv
decode/rbank.sv
decode/decode_stage.sv
execute/alu_stage.sv
memory/mem_stage.sv
source/cpu.sv
verification/cpu_tb.sv

/* Makefile */
# Verilator flow for the pipelined cpu

TB_TOP := cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module cpu -f compile.f
	verilator --lint-only --timing --top-module $(TB_TOP) -f compile.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB_TOP) \
		-f compile.f -Mdir obj_dir -o V$(TB_TOP)
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir
